/* ctrl_pkg.sv */
`default_nettype none

package ctrl_pkg;

  //////////////////////////////////////////////////////////////////////
  // Encodings
  //////////////////////////////////////////////////////////////////////

  // Main controller FSM
  typedef enum logic [1:0] {
    RESET      = 2'd0,
    BOOT_SET   = 2'd1,
    FUNCTIONAL = 2'd2,
    SLEEP      = 2'd3
  } ctrl_state_e;

  // Source of the next fetch PC
  typedef enum logic [2:0] {
    PC_BOOT     = 3'd0,
    PC_TRAP_EXC = 3'd1,
    PC_TRAP_IRQ = 3'd2,
    PC_TRAP_NMI = 3'd3,
    PC_MRET     = 3'd4
  } pc_mux_e;

  // MPU check result
  typedef enum logic [1:0] {
    MPU_OK       = 2'd0,
    MPU_RE_FAULT = 2'd1,
    MPU_WR_FAULT = 2'd2
  } mpu_status_e;

  // Stage whose PC goes into mepc
  typedef enum logic [2:0] {
    SAVE_NONE = 3'd0,
    SAVE_IF   = 3'd1,
    SAVE_ID   = 3'd2,
    SAVE_EX   = 3'd3,
    SAVE_WB   = 3'd4
  } save_sel_e;

  // Width of the mcause exception code field
  localparam int unsigned INT_CODE_W = 11;

  // Synchronous exception codes
  localparam logic [7:0] EXC_CAUSE_INSTR_FAULT     = 8'd1;
  localparam logic [7:0] EXC_CAUSE_ILLEGAL_INSN    = 8'd2;
  localparam logic [7:0] EXC_CAUSE_BREAKPOINT      = 8'd3;
  localparam logic [7:0] EXC_CAUSE_LOAD_FAULT      = 8'd5;
  localparam logic [7:0] EXC_CAUSE_STORE_FAULT     = 8'd7;
  localparam logic [7:0] EXC_CAUSE_ECALL_MMODE     = 8'd11;
  localparam logic [7:0] EXC_CAUSE_INSTR_BUS_FAULT = 8'd24;

  // NMI codes from imprecise load/store bus errors
  localparam logic [INT_CODE_W-1:0] INT_CAUSE_LSU_LOAD_FAULT  = 11'd1024;
  localparam logic [INT_CODE_W-1:0] INT_CAUSE_LSU_STORE_FAULT = 11'd1025;

  //////////////////////////////////////////////////////////////////////
  // Bundles
  //////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic        valid;
    mpu_status_e instr_mpu_status;
    logic        bus_err;
    logic        illegal;
    logic        ecall;
    logic        ebreak;
    logic        wfi;
    logic        mret;
  } wb_instr_t;

  typedef struct packed {
    logic id_valid;
    logic ex_valid;
  } pipe_valid_t;

  typedef struct packed {
    logic jr;
    logic load;
    logic csr;
    logic wfi;
  } stall_t;

  typedef struct packed {
    logic err;
    logic is_store;
  } lsu_err_t;

  typedef struct packed {
    logic       exception;
    logic [7:0] exc_cause;
    logic       wfi;
    logic       mret;
    logic       valid;
  } wb_event_t;

  // Interrupt id is carried zero-extended to the full code width
  typedef struct packed {
    logic                  nmi_pending;
    logic                  nmi_is_store;
    logic                  irq_pending;
    logic                  allowed;
    logic [INT_CODE_W-1:0] irq_id;
  } async_event_t;

  typedef struct packed {
    logic if_s;
    logic id_s;
    logic ex_s;
    logic wb_s;
  } stage_ctrl_t;

  typedef struct packed {
    save_sel_e             save_sel;
    logic                  save_cause;
    logic                  interrupt;
    logic [INT_CODE_W-1:0] code;
    logic                  restore_mret;
  } csr_ctrl_t;

endpackage

`default_nettype wire

/* wb_event_decode.sv */
`default_nettype none

module wb_event_decode (
  input  ctrl_pkg::wb_instr_t   wb_instr_i,
  input  ctrl_pkg::mpu_status_e lsu_mpu_status_i,
  output ctrl_pkg::wb_event_t   wb_event_o
);

  // Fault flags from the two MPU checks
  logic instr_mpu_fault;
  logic lsu_mpu_fault;
  logic any_exc;
  logic [7:0] exc_cause;

  assign instr_mpu_fault = (wb_instr_i.instr_mpu_status != ctrl_pkg::MPU_OK);
  assign lsu_mpu_fault   = (lsu_mpu_status_i != ctrl_pkg::MPU_OK);

  // Any synchronous trap source on the WB instruction
  assign any_exc = instr_mpu_fault    ||
                   wb_instr_i.bus_err ||
                   wb_instr_i.illegal ||
                   wb_instr_i.ecall   ||
                   wb_instr_i.ebreak  ||
                   lsu_mpu_fault;

  // Cause follows fetch side first, then decode, then data side
  always_comb begin
    if (instr_mpu_fault) begin
      exc_cause = ctrl_pkg::EXC_CAUSE_INSTR_FAULT;
    end else if (wb_instr_i.bus_err) begin
      exc_cause = ctrl_pkg::EXC_CAUSE_INSTR_BUS_FAULT;
    end else if (wb_instr_i.illegal) begin
      exc_cause = ctrl_pkg::EXC_CAUSE_ILLEGAL_INSN;
    end else if (wb_instr_i.ecall) begin
      exc_cause = ctrl_pkg::EXC_CAUSE_ECALL_MMODE;
    end else if (wb_instr_i.ebreak) begin
      exc_cause = ctrl_pkg::EXC_CAUSE_BREAKPOINT;
    end else if (lsu_mpu_status_i == ctrl_pkg::MPU_WR_FAULT) begin
      exc_cause = ctrl_pkg::EXC_CAUSE_STORE_FAULT;
    end else begin
      // Read fault, also the value when nothing is flagged
      exc_cause = ctrl_pkg::EXC_CAUSE_LOAD_FAULT;
    end
  end

  // Every event needs a valid instruction in WB
  assign wb_event_o.exception = any_exc && wb_instr_i.valid;
  assign wb_event_o.exc_cause = exc_cause;
  assign wb_event_o.wfi       = wb_instr_i.wfi && wb_instr_i.valid;
  assign wb_event_o.mret      = wb_instr_i.mret && wb_instr_i.valid;
  assign wb_event_o.valid     = wb_instr_i.valid;

endmodule

`default_nettype wire

/* async_event_tracker.sv */
`default_nettype none

module async_event_tracker #(
  parameter int unsigned IRQ_ID_W = 5
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  ctrl_pkg::lsu_err_t     lsu_err_i,
  input  logic                   nmi_taken_i,
  input  logic                   irq_req_i,
  input  logic [IRQ_ID_W-1:0]    irq_id_i,
  input  logic                   lsu_interruptible_i,
  output ctrl_pkg::async_event_t async_event_o
);

  // Sticky bus error, kept until the NMI handler is entered
  logic nmi_pending_q;
  // Set for a store error, clear for a load error
  logic nmi_is_store_q;

  //////////////////////////////////////////////////////////////////////
  // Sticky NMI
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      nmi_pending_q  <= 1'b0;
      nmi_is_store_q <= 1'b0;
    end else begin
      if (lsu_err_i.err && !nmi_pending_q) begin
        // First error wins, later ones leave the type alone
        nmi_pending_q  <= 1'b1;
        nmi_is_store_q <= lsu_err_i.is_store;
      end else if (nmi_taken_i) begin
        nmi_pending_q  <= 1'b0;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Event summary
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    async_event_o              = '0;
    async_event_o.nmi_pending  = nmi_pending_q;
    async_event_o.nmi_is_store = nmi_is_store_q;
    async_event_o.irq_pending  = irq_req_i;
    // LSU must not have a transfer in flight that cannot be undone
    async_event_o.allowed      = lsu_interruptible_i;
    // Upper id bits stay zero
    async_event_o.irq_id[IRQ_ID_W-1:0] = irq_id_i;
  end

endmodule

`default_nettype wire

/* trap_sequencer.sv */
`default_nettype none

module trap_sequencer #(
  parameter int unsigned IRQ_ID_W = 5
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   fetch_enable_i,
  input  logic                   irq_wu_i,
  input  ctrl_pkg::wb_event_t    wb_event_i,
  input  ctrl_pkg::async_event_t async_event_i,
  input  ctrl_pkg::pipe_valid_t  pipe_valid_i,
  input  ctrl_pkg::stall_t       stall_i,
  output logic                   nmi_taken_o,
  output logic                   instr_req_o,
  output logic                   ctrl_busy_o,
  output logic                   pc_set_o,
  output ctrl_pkg::pc_mux_e      pc_mux_o,
  output ctrl_pkg::stage_ctrl_t  kill_o,
  output ctrl_pkg::stage_ctrl_t  halt_o,
  output ctrl_pkg::csr_ctrl_t    csr_o,
  output logic                   irq_ack_o,
  output logic [IRQ_ID_W-1:0]    irq_id_o
);

  ctrl_pkg::ctrl_state_e ctrl_fsm_cs;
  ctrl_pkg::ctrl_state_e ctrl_fsm_ns;

  // Asynchronous events that may be taken right now
  logic take_nmi;
  logic take_irq;
  // Pending but held back by the LSU
  logic async_blocked;

  // Oldest stage holding a valid instruction, IF always has a PC
  function automatic ctrl_pkg::save_sel_e oldest_valid(
    input logic wb_valid,
    input ctrl_pkg::pipe_valid_t pv
  );
    ctrl_pkg::save_sel_e sel;
    if (wb_valid) begin
      sel = ctrl_pkg::SAVE_WB;
    end else if (pv.ex_valid) begin
      sel = ctrl_pkg::SAVE_EX;
    end else if (pv.id_valid) begin
      sel = ctrl_pkg::SAVE_ID;
    end else begin
      sel = ctrl_pkg::SAVE_IF;
    end
    return sel;
  endfunction

  assign take_nmi      = async_event_i.nmi_pending && async_event_i.allowed;
  assign take_irq      = async_event_i.irq_pending && async_event_i.allowed;
  assign async_blocked = (async_event_i.nmi_pending || async_event_i.irq_pending) &&
                         !async_event_i.allowed;

  //////////////////////////////////////////////////////////////////////
  // FSM and event priority
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    ctrl_fsm_ns = ctrl_fsm_cs;
    instr_req_o = 1'b1;
    ctrl_busy_o = 1'b1;
    pc_set_o    = 1'b0;
    pc_mux_o    = ctrl_pkg::PC_BOOT;
    kill_o      = '0;
    halt_o      = '0;
    csr_o       = '0;
    csr_o.save_sel = ctrl_pkg::SAVE_NONE;
    irq_ack_o   = 1'b0;
    irq_id_o    = '0;
    nmi_taken_o = 1'b0;

    // Regular stalls, plus a bubble so the LSU becomes interruptible
    halt_o.id_s = stall_i.jr || stall_i.load || stall_i.csr || stall_i.wfi ||
                  async_blocked;

    unique case (ctrl_fsm_cs)
      ctrl_pkg::RESET: begin
        instr_req_o = 1'b0;
        if (fetch_enable_i) begin
          ctrl_fsm_ns = ctrl_pkg::BOOT_SET;
        end
      end
      // Separate cycle keeps fetch_enable_i off the fetch PC path
      ctrl_pkg::BOOT_SET: begin
        pc_set_o    = 1'b1;
        pc_mux_o    = ctrl_pkg::PC_BOOT;
        ctrl_fsm_ns = ctrl_pkg::FUNCTIONAL;
      end
      ctrl_pkg::FUNCTIONAL: begin
        if (take_nmi || take_irq) begin
          // Flush everything and enter the handler
          kill_o           = '1;
          pc_set_o         = 1'b1;
          csr_o.save_sel   = oldest_valid(wb_event_i.valid, pipe_valid_i);
          csr_o.save_cause = 1'b1;
          csr_o.interrupt  = 1'b1;
          if (take_nmi) begin
            // NMI beats a regular interrupt in the same cycle
            nmi_taken_o = 1'b1;
            pc_mux_o    = ctrl_pkg::PC_TRAP_NMI;
            csr_o.code  = async_event_i.nmi_is_store ?
                          ctrl_pkg::INT_CAUSE_LSU_STORE_FAULT :
                          ctrl_pkg::INT_CAUSE_LSU_LOAD_FAULT;
          end else begin
            pc_mux_o   = ctrl_pkg::PC_TRAP_IRQ;
            csr_o.code = async_event_i.irq_id;
            irq_ack_o  = 1'b1;
            irq_id_o   = async_event_i.irq_id[IRQ_ID_W-1:0];
          end
        end else if (wb_event_i.exception) begin
          // WB write enables are already suppressed, WB itself survives
          kill_o.if_s      = 1'b1;
          kill_o.id_s      = 1'b1;
          kill_o.ex_s      = 1'b1;
          pc_set_o         = 1'b1;
          pc_mux_o         = ctrl_pkg::PC_TRAP_EXC;
          csr_o.save_sel   = ctrl_pkg::SAVE_WB;
          csr_o.save_cause = 1'b1;
          csr_o.code       = {3'b000, wb_event_i.exc_cause};
        end else if (wb_event_i.wfi) begin
          ctrl_fsm_ns = ctrl_pkg::SLEEP;
        end else if (wb_event_i.mret) begin
          // mstatus and privilege come back from the saved copy
          csr_o.restore_mret = 1'b1;
        end
      end
      ctrl_pkg::SLEEP: begin
        instr_req_o = 1'b0;
        ctrl_busy_o = 1'b0;
        // Keep younger instructions from retiring while asleep
        halt_o.wb_s = 1'b1;
        if (irq_wu_i) begin
          ctrl_busy_o = 1'b1;
          ctrl_fsm_ns = ctrl_pkg::FUNCTIONAL;
        end
      end
      default: begin
        instr_req_o = 1'b0;
        ctrl_fsm_ns = ctrl_pkg::RESET;
      end
    endcase
  end

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      ctrl_fsm_cs <= ctrl_pkg::RESET;
    end else begin
      ctrl_fsm_cs <= ctrl_fsm_ns;
    end
  end

endmodule

`default_nettype wire

/* ctrl_top.sv */
`default_nettype none

module ctrl_top #(
  parameter int unsigned IRQ_ID_W = 5
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  fetch_enable_i,
  input  ctrl_pkg::wb_instr_t   wb_instr_i,
  input  ctrl_pkg::mpu_status_e lsu_mpu_status_i,
  input  ctrl_pkg::pipe_valid_t pipe_valid_i,
  input  ctrl_pkg::stall_t      stall_i,
  input  ctrl_pkg::lsu_err_t    lsu_err_i,
  input  logic                  irq_req_i,
  input  logic [IRQ_ID_W-1:0]   irq_id_i,
  input  logic                  irq_wu_i,
  input  logic                  lsu_interruptible_i,
  output logic                  instr_req_o,
  output logic                  ctrl_busy_o,
  output logic                  pc_set_o,
  output ctrl_pkg::pc_mux_e     pc_mux_o,
  output ctrl_pkg::stage_ctrl_t kill_o,
  output ctrl_pkg::stage_ctrl_t halt_o,
  output ctrl_pkg::csr_ctrl_t   csr_o,
  output logic                  irq_ack_o,
  output logic [IRQ_ID_W-1:0]   irq_id_o
);

  ctrl_pkg::wb_event_t    wb_event;
  ctrl_pkg::async_event_t async_event;
  // Clears the sticky NMI when its trap is taken
  logic                   nmi_taken;

  wb_event_decode wb_event_decode_i (
    .wb_instr_i       (wb_instr_i),
    .lsu_mpu_status_i (lsu_mpu_status_i),
    .wb_event_o       (wb_event)
  );

  async_event_tracker #(
    .IRQ_ID_W (IRQ_ID_W)
  ) async_event_tracker_i (
    .clk                 (clk),
    .rst_n               (rst_n),
    .lsu_err_i           (lsu_err_i),
    .nmi_taken_i         (nmi_taken),
    .irq_req_i           (irq_req_i),
    .irq_id_i            (irq_id_i),
    .lsu_interruptible_i (lsu_interruptible_i),
    .async_event_o       (async_event)
  );

  trap_sequencer #(
    .IRQ_ID_W (IRQ_ID_W)
  ) trap_sequencer_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .fetch_enable_i (fetch_enable_i),
    .irq_wu_i       (irq_wu_i),
    .wb_event_i     (wb_event),
    .async_event_i  (async_event),
    .pipe_valid_i   (pipe_valid_i),
    .stall_i        (stall_i),
    .nmi_taken_o    (nmi_taken),
    .instr_req_o    (instr_req_o),
    .ctrl_busy_o    (ctrl_busy_o),
    .pc_set_o       (pc_set_o),
    .pc_mux_o       (pc_mux_o),
    .kill_o         (kill_o),
    .halt_o         (halt_o),
    .csr_o          (csr_o),
    .irq_ack_o      (irq_ack_o),
    .irq_id_o       (irq_id_o)
  );

endmodule

`default_nettype wire

/* ctrl_properties.sv */
`default_nettype none

module ctrl_properties (
  input logic                  clk,
  input logic                  rst_n,
  input ctrl_pkg::ctrl_state_e state_i,
  input logic                  pc_set_i,
  input logic                  instr_req_i,
  input ctrl_pkg::stage_ctrl_t kill_i,
  input logic                  irq_ack_i
);

  timeunit 1ns;
  timeprecision 1ps;

  // No fetch redirect before boot
  a_no_pc_set_in_reset: assert property (
    @(posedge clk) disable iff (!rst_n)
    (state_i == ctrl_pkg::RESET) |-> !pc_set_i
  ) else $error("pc_set_o is high in RESET");

  // Interrupt entry flushes the whole pipeline
  a_irq_ack_kills_all: assert property (
    @(posedge clk) disable iff (!rst_n)
    irq_ack_i |-> (kill_i.if_s && kill_i.id_s && kill_i.ex_s && kill_i.wb_s)
  ) else $error("irq_ack_o without all four kill bits");

  // Fetch is off while asleep
  a_sleep_no_fetch: assert property (
    @(posedge clk) disable iff (!rst_n)
    (state_i == ctrl_pkg::SLEEP) |-> !instr_req_i
  ) else $error("instr_req_o is high in SLEEP");

endmodule

bind trap_sequencer ctrl_properties ctrl_properties_i (
  .clk         (clk),
  .rst_n       (rst_n),
  .state_i     (ctrl_fsm_cs),
  .pc_set_i    (pc_set_o),
  .instr_req_i (instr_req_o),
  .kill_i      (kill_o),
  .irq_ack_i   (irq_ack_o)
);

`default_nettype wire

/* tb_ctrl_top.sv */
`default_nettype none

module tb_ctrl_top;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned IRQ_ID_W   = 5;
  // About 1630 stimulus cycles plus margin
  localparam int unsigned MAX_CYCLES = 2000;

  // Predicted controller outputs and next FSM state
  typedef struct packed {
    logic                  instr_req;
    logic                  ctrl_busy;
    logic                  pc_set;
    ctrl_pkg::pc_mux_e     pc_mux;
    ctrl_pkg::stage_ctrl_t kill;
    ctrl_pkg::stage_ctrl_t halt;
    ctrl_pkg::csr_ctrl_t   csr;
    logic                  irq_ack;
    logic [IRQ_ID_W-1:0]   irq_id;
    logic                  nmi_taken;
    ctrl_pkg::ctrl_state_e next_state;
  } ctrl_exp_t;

  logic                  clk;
  logic                  rst_n;
  logic                  fetch_enable_i;
  ctrl_pkg::wb_instr_t   wb_instr_i;
  ctrl_pkg::mpu_status_e lsu_mpu_status_i;
  ctrl_pkg::pipe_valid_t pipe_valid_i;
  ctrl_pkg::stall_t      stall_i;
  ctrl_pkg::lsu_err_t    lsu_err_i;
  logic                  irq_req_i;
  logic [IRQ_ID_W-1:0]   irq_id_i;
  logic                  irq_wu_i;
  logic                  lsu_interruptible_i;
  logic                  instr_req_o;
  logic                  ctrl_busy_o;
  logic                  pc_set_o;
  ctrl_pkg::pc_mux_e     pc_mux_o;
  ctrl_pkg::stage_ctrl_t kill_o;
  ctrl_pkg::stage_ctrl_t halt_o;
  ctrl_pkg::csr_ctrl_t   csr_o;
  logic                  irq_ack_o;
  logic [IRQ_ID_W-1:0]   irq_id_o;

  // Reference copy of the FSM state and the sticky NMI
  ctrl_pkg::ctrl_state_e model_state;
  logic                  model_nmi_pending;
  logic                  model_nmi_is_store;

  int unsigned error_count = 0;
  int unsigned check_count = 0;
  int unsigned cycle_count = 0;

  ctrl_top #(
    .IRQ_ID_W (IRQ_ID_W)
  ) ctrl_top_i (
    .clk                 (clk),
    .rst_n               (rst_n),
    .fetch_enable_i      (fetch_enable_i),
    .wb_instr_i          (wb_instr_i),
    .lsu_mpu_status_i    (lsu_mpu_status_i),
    .pipe_valid_i        (pipe_valid_i),
    .stall_i             (stall_i),
    .lsu_err_i           (lsu_err_i),
    .irq_req_i           (irq_req_i),
    .irq_id_i            (irq_id_i),
    .irq_wu_i            (irq_wu_i),
    .lsu_interruptible_i (lsu_interruptible_i),
    .instr_req_o         (instr_req_o),
    .ctrl_busy_o         (ctrl_busy_o),
    .pc_set_o            (pc_set_o),
    .pc_mux_o            (pc_mux_o),
    .kill_o              (kill_o),
    .halt_o              (halt_o),
    .csr_o               (csr_o),
    .irq_ack_o           (irq_ack_o),
    .irq_id_o            (irq_id_o)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  //////////////////////////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////////////////////////

  function automatic ctrl_exp_t expected_ctrl(
    input ctrl_pkg::ctrl_state_e state,
    input logic                  nmi_pend,
    input logic                  nmi_store,
    input ctrl_pkg::wb_instr_t   wb,
    input ctrl_pkg::mpu_status_e lsu_mpu,
    input ctrl_pkg::pipe_valid_t pv,
    input ctrl_pkg::stall_t      st,
    input logic                  irq_req,
    input logic [IRQ_ID_W-1:0]   irq_id,
    input logic                  allowed,
    input logic                  fetch_en,
    input logic                  wake
  );
    ctrl_exp_t  e;
    logic       exc;
    logic [7:0] cause;
    e            = '0;
    e.next_state = state;
    e.instr_req  = 1'b1;
    e.ctrl_busy  = 1'b1;
    // Any stall, or a blocked NMI or interrupt, holds ID
    e.halt.id_s  = st.jr || st.load || st.csr || st.wfi ||
                   ((nmi_pend || irq_req) && !allowed);
    exc = wb.valid && (wb.instr_mpu_status != ctrl_pkg::MPU_OK || wb.bus_err ||
          wb.illegal || wb.ecall || wb.ebreak || lsu_mpu != ctrl_pkg::MPU_OK);
    // Cause priority, fetch side first
    if (wb.instr_mpu_status != ctrl_pkg::MPU_OK) begin
      cause = 8'd1;
    end else if (wb.bus_err) begin
      cause = 8'd24;
    end else if (wb.illegal) begin
      cause = 8'd2;
    end else if (wb.ecall) begin
      cause = 8'd11;
    end else if (wb.ebreak) begin
      cause = 8'd3;
    end else begin
      cause = (lsu_mpu == ctrl_pkg::MPU_WR_FAULT) ? 8'd7 : 8'd5;
    end
    case (state)
      ctrl_pkg::RESET: begin
        e.instr_req = 1'b0;
        if (fetch_en) begin
          e.next_state = ctrl_pkg::BOOT_SET;
        end
      end
      ctrl_pkg::BOOT_SET: begin
        e.pc_set     = 1'b1;
        e.next_state = ctrl_pkg::FUNCTIONAL;
      end
      ctrl_pkg::FUNCTIONAL: begin
        if ((nmi_pend || irq_req) && allowed) begin
          e.kill           = '1;
          e.pc_set         = 1'b1;
          e.csr.save_cause = 1'b1;
          e.csr.interrupt  = 1'b1;
          // Oldest valid stage owns mepc
          if (wb.valid) begin
            e.csr.save_sel = ctrl_pkg::SAVE_WB;
          end else if (pv.ex_valid) begin
            e.csr.save_sel = ctrl_pkg::SAVE_EX;
          end else if (pv.id_valid) begin
            e.csr.save_sel = ctrl_pkg::SAVE_ID;
          end else begin
            e.csr.save_sel = ctrl_pkg::SAVE_IF;
          end
          if (nmi_pend) begin
            e.nmi_taken = 1'b1;
            e.pc_mux    = ctrl_pkg::PC_TRAP_NMI;
            e.csr.code  = nmi_store ? 11'd1025 : 11'd1024;
          end else begin
            e.pc_mux    = ctrl_pkg::PC_TRAP_IRQ;
            e.csr.code  = 11'(irq_id);
            e.irq_ack   = 1'b1;
            e.irq_id    = irq_id;
          end
        end else if (exc) begin
          e.kill.if_s      = 1'b1;
          e.kill.id_s      = 1'b1;
          e.kill.ex_s      = 1'b1;
          e.pc_set         = 1'b1;
          e.pc_mux         = ctrl_pkg::PC_TRAP_EXC;
          e.csr.save_sel   = ctrl_pkg::SAVE_WB;
          e.csr.save_cause = 1'b1;
          e.csr.code       = {3'b000, cause};
        end else if (wb.valid && wb.wfi) begin
          e.next_state = ctrl_pkg::SLEEP;
        end else if (wb.valid && wb.mret) begin
          e.csr.restore_mret = 1'b1;
        end
      end
      ctrl_pkg::SLEEP: begin
        e.instr_req = 1'b0;
        e.ctrl_busy = wake;
        e.halt.wb_s = 1'b1;
        if (wake) begin
          e.next_state = ctrl_pkg::FUNCTIONAL;
        end
      end
      default: begin
        e.instr_req  = 1'b0;
        e.next_state = ctrl_pkg::RESET;
      end
    endcase
    return e;
  endfunction

  task automatic check_value(
    input string       name,
    input logic [31:0] actual,
    input logic [31:0] expected
  );
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("FAILED at %0t: %s is 0x%0h, expected 0x%0h", $time, name, actual, expected);
    end
  endtask

  // Outputs are stable half a cycle after the drive edge
  always @(negedge clk) begin : compare_outputs
    ctrl_exp_t predicted;
    if (!rst_n) begin
      model_state        = ctrl_pkg::RESET;
      model_nmi_pending  = 1'b0;
      model_nmi_is_store = 1'b0;
    end else begin
      predicted = expected_ctrl(model_state, model_nmi_pending, model_nmi_is_store,
                                wb_instr_i, lsu_mpu_status_i, pipe_valid_i, stall_i,
                                irq_req_i, irq_id_i, lsu_interruptible_i,
                                fetch_enable_i, irq_wu_i);
      check_value("instr_req_o", 32'(instr_req_o), 32'(predicted.instr_req));
      check_value("ctrl_busy_o", 32'(ctrl_busy_o), 32'(predicted.ctrl_busy));
      check_value("pc_set_o", 32'(pc_set_o), 32'(predicted.pc_set));
      check_value("pc_mux_o", 32'(pc_mux_o), 32'(predicted.pc_mux));
      check_value("kill_o", 32'(kill_o), 32'(predicted.kill));
      check_value("halt_o", 32'(halt_o), 32'(predicted.halt));
      check_value("csr_o", 32'(csr_o), 32'(predicted.csr));
      check_value("irq_ack_o", 32'(irq_ack_o), 32'(predicted.irq_ack));
      check_value("irq_id_o", 32'(irq_id_o), 32'(predicted.irq_id));
      // Advance the model to what the next edge will do
      model_state = predicted.next_state;
      if (lsu_err_i.err && !model_nmi_pending) begin
        model_nmi_pending  = 1'b1;
        model_nmi_is_store = lsu_err_i.is_store;
      end else if (predicted.nmi_taken) begin
        model_nmi_pending  = 1'b0;
      end
    end
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= MAX_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////////////////////////

  // True with a chance of one in n
  function automatic logic one_in(input int unsigned n);
    return ($urandom_range(n - 1, 0) == 0);
  endfunction

  function automatic ctrl_pkg::mpu_status_e random_mpu(input logic en);
    if (!en || !one_in(10)) begin
      return ctrl_pkg::MPU_OK;
    end
    return one_in(2) ? ctrl_pkg::MPU_WR_FAULT : ctrl_pkg::MPU_RE_FAULT;
  endfunction

  task automatic drive_random(
    input int unsigned cycles,
    input logic        exc_en,
    input logic        irq_en,
    input logic        nmi_en,
    input logic        wfi_en,
    input logic        mret_en
  );
    ctrl_pkg::wb_instr_t wb;
    ctrl_pkg::stall_t    st;
    ctrl_pkg::lsu_err_t  err;
    repeat (cycles) begin
      @(posedge clk);
      wb                  = '0;
      wb.valid            = !one_in(4);
      wb.instr_mpu_status = random_mpu(exc_en);
      wb.bus_err          = exc_en && one_in(10);
      wb.illegal          = exc_en && one_in(10);
      wb.ecall            = exc_en && one_in(10);
      wb.ebreak           = exc_en && one_in(10);
      wb.wfi              = wfi_en && one_in(5);
      wb.mret             = mret_en && one_in(3);
      st.jr               = one_in(12);
      st.load             = one_in(12);
      st.csr              = one_in(12);
      st.wfi              = one_in(12);
      err.err             = nmi_en && one_in(12);
      err.is_store        = one_in(2);
      wb_instr_i          <= wb;
      lsu_mpu_status_i    <= random_mpu(exc_en);
      pipe_valid_i        <= 2'($urandom);
      stall_i             <= st;
      lsu_err_i           <= err;
      irq_req_i           <= irq_en && one_in(3);
      irq_id_i            <= IRQ_ID_W'($urandom);
      irq_wu_i            <= wfi_en && one_in(6);
      // Random back-pressure only where async events occur
      lsu_interruptible_i <= (irq_en || nmi_en) ? one_in(2) : 1'b1;
    end
  endtask

  initial begin
    void'($urandom(98));
    rst_n               = 1'b0;
    fetch_enable_i      = 1'b0;
    wb_instr_i          = '0;
    lsu_mpu_status_i    = ctrl_pkg::MPU_OK;
    pipe_valid_i        = '0;
    stall_i             = '0;
    lsu_err_i           = '0;
    irq_req_i           = 1'b0;
    irq_id_i            = '0;
    irq_wu_i            = 1'b0;
    lsu_interruptible_i = 1'b1;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    // Fetch stays off until enabled, then one boot redirect
    repeat (4) @(posedge clk);
    fetch_enable_i <= 1'b1;
    repeat (5) @(posedge clk);
    // Exceptions, interrupts, NMI, sleep, mret, then everything mixed
    drive_random(300, 1'b1, 1'b0, 1'b0, 1'b0, 1'b1);
    drive_random(300, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0);
    drive_random(300, 1'b0, 1'b1, 1'b1, 1'b0, 1'b0);
    drive_random(200, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0);
    drive_random(200, 1'b0, 1'b1, 1'b0, 1'b0, 1'b1);
    drive_random(300, 1'b1, 1'b1, 1'b1, 1'b1, 1'b1);
    @(posedge clk);
    wb_instr_i <= '0;
    irq_req_i  <= 1'b0;
    lsu_err_i  <= '0;
    repeat (2) @(posedge clk);
    $display("Checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verilog.f */
ctrl_pkg.sv
wb_event_decode.sv
async_event_tracker.sv
trap_sequencer.sv
ctrl_top.sv
ctrl_properties.sv
tb_ctrl_top.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the controller testbench, pass only if the log holds the pass line
rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/1ps --top-module tb_ctrl_top \
  -f verilog.f -o sim_ctrl_top > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/sim_ctrl_top > sim.log 2>&1 ; cat sim.log
grep -q "^SIMULATION PASSED$" sim.log && exit 0 || exit 1
